// File: hdl/bimodal_table.sv
// Bimodal base predictor of PC-indexed saturating counters
`timescale 1ns/1ps

module bimodal_table
    import bp_geom_pkg::*;
    import bp_ctr_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    // Combinational lookup
    input  logic [PC_W-1:0] query_pc_i,
    output logic            taken_o,

    // Resolved branch
    input  logic            upd_valid_i,
    input  logic [PC_W-1:0] upd_pc_i,
    input  logic            upd_taken_i
);

    localparam int DEPTH = 2 ** BASE_IDX_W;

    logic [CTR_W-1:0]      ctr_q [DEPTH];
    logic [BASE_IDX_W-1:0] q_idx;
    logic [BASE_IDX_W-1:0] u_idx;

    // Instructions are word aligned, skip the two low PC bits
    assign q_idx = query_pc_i[BASE_IDX_W+1:2];
    assign u_idx = upd_pc_i[BASE_IDX_W+1:2];

    // Upper half of the counter range means taken
    assign taken_o = ctr_q[q_idx][CTR_W-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (upd_valid_i) begin
            ctr_q[u_idx] <= ctr_next(ctr_q[u_idx], upd_taken_i);
        end
    end

endmodule

// File: hdl/bp_comp_if.sv
// Query and answer bundle between the top level and one tagged component
`timescale 1ns/1ps

interface bp_comp_if
    import bp_geom_pkg::*;
();

    // Query side, owned by the parent
    logic [PC_W-1:0]  q_pc;
    logic [GHR_W-1:0] q_hist;

    // Answer side, owned by the component
    logic             q_taken;
    logic             q_hit;

    modport comp (
        input  q_pc,
        input  q_hist,
        output q_taken,
        output q_hit
    );

    modport parent (
        output q_pc,
        output q_hist,
        input  q_taken,
        input  q_hit
    );

endinterface

// File: hdl/bp_ctr_pkg.sv
// Saturating direction counters and the provider code
package bp_ctr_pkg;

    localparam int CTR_W = 3;

    // Weakly taken
    localparam logic [CTR_W-1:0] CTR_RESET = 3'b100;
    localparam logic [CTR_W-1:0] CTR_MAX   = '1;
    localparam logic [CTR_W-1:0] CTR_MIN   = '0;

    // Which component supplied the final direction
    typedef enum logic [1:0] {
        PROV_BASE  = 2'd0,
        PROV_SHORT = 2'd1,
        PROV_LONG  = 2'd2
    } provider_t;

    // One resolved outcome applied to a counter, clamped at both ends
    function automatic logic [CTR_W-1:0] ctr_next(input logic [CTR_W-1:0] ctr,
                                                  input logic taken);
        logic [CTR_W-1:0] nxt;
        nxt = ctr;
        if (taken && (ctr != CTR_MAX)) begin
            nxt = ctr + 1'b1;
        end else if (!taken && (ctr != CTR_MIN)) begin
            nxt = ctr - 1'b1;
        end
        return nxt;
    endfunction

endpackage

// File: hdl/bp_geom_pkg.sv
// Predictor geometry: PC width, history length and table sizes
package bp_geom_pkg;

    // Program counter width
    localparam int PC_W = 32;

    // Global history length, one more than the longest folded length
    localparam int GHR_W = 9;

    // Base table index width, depth is 2**BASE_IDX_W
    localparam int BASE_IDX_W = 8;

    // Tagged table depth exponent
    localparam int TAG_IDX_W = 7;

    // Partial tag width stored per tagged entry
    localparam int TAG_W = 8;

    // Past queries remembered by each tagged component
    localparam int QBUF_DEPTH = 6;

    // Folded history lengths of the two tagged components
    localparam int HIST_SHORT = 4;
    localparam int HIST_LONG  = 8;

endpackage

// File: hdl/first_set_encoder.sv
// Priority encoder returning the position of the lowest set line
`timescale 1ns/1ps

module first_set_encoder #(
    parameter int LINES = 6
) (
    input  logic [LINES-1:0]         lines_i,
    output logic [$clog2(LINES)-1:0] index_o
);

    localparam int IDX_W = $clog2(LINES);

    // Scan from the top so the lowest set line is written last
    always_comb begin
        index_o = '0;
        for (int i = LINES - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                index_o = IDX_W'(i);
            end
        end
    end

    // Zero doubles as "nothing set"; callers keep line 0 low
    // when they need to tell the two apart

endmodule

// File: hdl/history_reg.sv
// Global branch history, one bit per resolved conditional branch
`timescale 1ns/1ps

module history_reg
    import bp_geom_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             upd_valid_i,
    input  logic             upd_taken_i,
    output logic [GHR_W-1:0] ghr_o
);

    logic [GHR_W-1:0] ghr_q;

    // Newest outcome enters at bit 0, oldest falls off the top
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (upd_valid_i) begin
            ghr_q <= {ghr_q[GHR_W-2:0], upd_taken_i};
        end
    end

    assign ghr_o = ghr_q;

endmodule

// File: hdl/tage_predictor.sv
// Two-table TAGE direction predictor with bimodal fallback
`timescale 1ns/1ps

module tage_predictor
    import bp_geom_pkg::*;
    import bp_ctr_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic [PC_W-1:0]  query_pc_i,

    input  logic             upd_valid_i,
    input  logic [PC_W-1:0]  upd_pc_i,
    input  logic             upd_taken_i,

    output logic             pred_taken_o,
    output provider_t        provider_o,
    output logic [GHR_W-1:0] ghr_o
);

    logic [GHR_W-1:0] ghr;
    logic             base_taken;

    bp_comp_if short_if ();
    bp_comp_if long_if ();

    history_reg u_history (
        .clk         (clk),
        .rst_n       (rst_n),
        .upd_valid_i (upd_valid_i),
        .upd_taken_i (upd_taken_i),
        .ghr_o       (ghr)
    );

    bimodal_table u_base (
        .clk         (clk),
        .rst_n       (rst_n),
        .query_pc_i  (query_pc_i),
        .taken_o     (base_taken),
        .upd_valid_i (upd_valid_i),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i)
    );

    // Both components see the same query and history
    assign short_if.q_pc   = query_pc_i;
    assign short_if.q_hist = ghr;
    assign long_if.q_pc    = query_pc_i;
    assign long_if.q_hist  = ghr;

    tagged_predictor #(.HIST_LEN(HIST_SHORT)) u_short (
        .clk         (clk),
        .rst_n       (rst_n),
        .comp        (short_if),
        .upd_valid_i (upd_valid_i),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i)
    );

    tagged_predictor #(.HIST_LEN(HIST_LONG)) u_long (
        .clk         (clk),
        .rst_n       (rst_n),
        .comp        (long_if),
        .upd_valid_i (upd_valid_i),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i)
    );

    // Longest matching history wins
    always_comb begin
        if (long_if.q_hit) begin
            pred_taken_o = long_if.q_taken;
            provider_o   = PROV_LONG;
        end else if (short_if.q_hit) begin
            pred_taken_o = short_if.q_taken;
            provider_o   = PROV_SHORT;
        end else begin
            pred_taken_o = base_taken;
            provider_o   = PROV_BASE;
        end
    end

    assign ghr_o = ghr;

endmodule

// File: hdl/tagged_predictor.sv
// Tagged predictor component with folded history index and query replay buffer
`timescale 1ns/1ps

module tagged_predictor
    import bp_geom_pkg::*;
    import bp_ctr_pkg::*;
#(
    parameter int HIST_LEN = HIST_SHORT
) (
    input  logic            clk,
    input  logic            rst_n,

    bp_comp_if.comp         comp,

    // Resolved branch, shared with the other components
    input  logic            upd_valid_i,
    input  logic [PC_W-1:0] upd_pc_i,
    input  logic            upd_taken_i
);

    localparam int DEPTH = 2 ** TAG_IDX_W;
    localparam int SEL_W = $clog2(QBUF_DEPTH);

    // What a past query used, so an update can find the same entry
    typedef struct packed {
        logic [PC_W-1:0]      pc;
        logic [TAG_IDX_W-1:0] idx;
        logic [TAG_W-1:0]     tag;
    } qent_t;

    logic [CTR_W-1:0] ctr_q [DEPTH];
    logic [TAG_W-1:0] tag_q [DEPTH];

    // Circular shift registers for index folding and tag hashing
    logic [TAG_IDX_W-1:0] fold_q;
    logic [TAG_IDX_W-1:0] fold_d;
    logic [TAG_W-1:0]     csr1_q;
    logic [TAG_W-1:0]     csr1_d;
    logic [TAG_W-2:0]     csr2_q;
    logic [TAG_W-2:0]     csr2_d;

    logic [TAG_IDX_W-1:0] q_idx;
    logic [TAG_W-1:0]     q_tag;

    qent_t                 cur_ent;
    qent_t                 qbuf [1:QBUF_DEPTH-1];
    logic [QBUF_DEPTH-1:1] qvalid_q;
    logic [QBUF_DEPTH-1:0] match_lines;
    logic [SEL_W-1:0]      hit_sel;
    logic                  upd_hit;
    qent_t                 upd_ent;

    // Bit entering the window and bit leaving it both go into the fold
    assign fold_d = {fold_q[TAG_IDX_W-2:0],
                     fold_q[TAG_IDX_W-1] ^ comp.q_hist[0] ^ comp.q_hist[HIST_LEN]};

    // The two tag registers feed each other so they never align
    assign csr1_d = {csr1_q[TAG_W-2:0], csr2_q[TAG_W-2] ^ comp.q_hist[HIST_LEN]};
    assign csr2_d = {csr2_q[TAG_W-3:0], csr1_q[TAG_W-1] ^ comp.q_hist[0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fold_q <= '0;
            csr1_q <= '0;
            csr2_q <= '0;
        end else begin
            fold_q <= fold_d;
            csr1_q <= csr1_d;
            csr2_q <= csr2_d;
        end
    end

    // Index mixes the fold with two word-aligned PC slices
    assign q_idx = fold_q
                 ^ comp.q_pc[TAG_IDX_W+1:2]
                 ^ comp.q_pc[2*TAG_IDX_W+1:TAG_IDX_W+2];
    assign q_tag = comp.q_pc[TAG_W+1:2] ^ csr1_q ^ {csr2_q, 1'b0};

    assign comp.q_taken = ctr_q[q_idx][CTR_W-1];
    assign comp.q_hit   = (tag_q[q_idx] == q_tag);

    assign cur_ent = '{pc: comp.q_pc, idx: q_idx, tag: q_tag};

    // Entry i holds the query from i cycles ago
    always_ff @(posedge clk) begin
        qbuf[1] <= cur_ent;
        for (int i = 2; i < QBUF_DEPTH; i++) begin
            qbuf[i] <= qbuf[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qvalid_q <= '0;
        end else begin
            qvalid_q <= {qvalid_q[QBUF_DEPTH-2:1], 1'b1};
        end
    end

    // Line 0 stays low so a zero select means no usable match
    always_comb begin
        match_lines = '0;
        for (int i = 1; i < QBUF_DEPTH; i++) begin
            match_lines[i] = qvalid_q[i] && (qbuf[i].pc == upd_pc_i);
        end
    end

    first_set_encoder #(
        .LINES (QBUF_DEPTH)
    ) u_first_set (
        .lines_i (match_lines),
        .index_o (hit_sel)
    );

    assign upd_hit = (hit_sel != '0);

    always_comb begin
        upd_ent = '0;
        for (int i = 1; i < QBUF_DEPTH; i++) begin
            if (hit_sel == SEL_W'(i)) begin
                upd_ent = qbuf[i];
            end
        end
    end

    // Train the entry the query read; a different tag there is replaced
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= CTR_RESET;
                tag_q[i] <= '0;
            end
        end else if (upd_valid_i && upd_hit) begin
            ctr_q[upd_ent.idx] <= ctr_next(ctr_q[upd_ent.idx], upd_taken_i);
            if (tag_q[upd_ent.idx] != upd_ent.tag) begin
                tag_q[upd_ent.idx] <= upd_ent.tag;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the TAGE predictor testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tage_predictor_tb \
    -f verilog.f -o tage_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tage_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && exit 0 || exit 1

// File: tb/tage_cases.txt
# query_pc upd_valid upd_pc upd_taken exp_pred_taken exp_provider
# exp_provider: 0 base, 1 short, 2 long, x not checked
00001004 0 00000000 0 1 0
00001008 0 00000000 0 1 0
00001004 1 00002010 0 1 0
00001008 1 00002010 0 1 0
00002010 0 00000000 0 0 0
00003020 0 00000000 0 1 0
00001004 0 00000000 0 1 0
00001008 0 00000000 0 1 0
0000100c 0 00000000 0 1 0
00001004 0 00000000 0 1 0
00001008 0 00000000 0 1 0
0000100c 1 00003020 0 1 0
00001004 1 00003020 0 1 0
00003020 0 00000000 0 0 0
00001008 1 00004040 1 1 0
0000100c 1 00004040 1 1 x
00001004 1 00004040 1 1 x
00001008 1 00004040 1 1 x
0000100c 1 00004040 1 1 x
00001004 1 00004040 0 1 x
00004040 0 00000000 0 1 x
00001008 1 00005080 0 1 x
0000100c 1 000060c0 1 1 x
00001004 1 00007100 0 1 x
00001008 1 00005080 1 1 x
00004040 1 000060c0 0 1 x
0000100c 1 00007100 1 1 x
00001004 1 00005080 0 1 x
00001008 0 00000000 0 1 x
0000100c 0 00000000 0 1 x
00001004 1 000060c0 1 1 x
00001008 1 00007100 0 1 x
00004040 1 00005080 1 1 x
0000100c 0 00000000 0 1 x

// File: tb/tage_predictor_checker.sv
// Bound assertions on the TAGE predictor's top-level outputs
`timescale 1ns/1ps

module tage_predictor_checker
    import bp_geom_pkg::*;
    import bp_ctr_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic             upd_valid_i,
    input logic             pred_taken_o,
    input provider_t        provider_o,
    input logic [GHR_W-1:0] ghr_o
);

    // Only the three defined provider codes
    provider_legal: assert property (@(posedge clk) disable iff (!rst_n)
        provider_o inside {PROV_BASE, PROV_SHORT, PROV_LONG})
        else $error("provider_o holds an undefined code");

    // History moves only after an update strobe
    ghr_only_on_update: assert property (@(posedge clk) disable iff (!rst_n)
        !upd_valid_i |=> $stable(ghr_o))
        else $error("ghr_o changed without an update in the previous cycle");

    outputs_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({pred_taken_o, provider_o, ghr_o}))
        else $error("predictor outputs hold unknown bits");

endmodule

bind tage_predictor tage_predictor_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .upd_valid_i  (upd_valid_i),
    .pred_taken_o (pred_taken_o),
    .provider_o   (provider_o),
    .ghr_o        (ghr_o)
);

// File: tb/tage_predictor_tb.sv
// Testbench for the TAGE predictor: case file replay, random base updates, summary
`timescale 1ns/1ps

module tage_predictor_tb
    import bp_geom_pkg::*;
    import bp_ctr_pkg::*;
();

    localparam int MAX_LINES     = 200;
    localparam int RESET_LIMIT   = 8;
    localparam int SETTLE_LIMIT  = 8;
    localparam int RANDOM_ROUNDS = 20;

    logic             clk;
    logic             rst_n;
    logic [PC_W-1:0]  query_pc_i;
    logic             upd_valid_i;
    logic [PC_W-1:0]  upd_pc_i;
    logic             upd_taken_i;
    logic             pred_taken_o;
    provider_t        provider_o;
    logic [GHR_W-1:0] ghr_o;

    // Reference base counters and history, built from the update stream
    logic [CTR_W-1:0] base_model [2**BASE_IDX_W];
    logic [GHR_W-1:0] exp_ghr;
    logic [31:0]      rand_state;
    int               check_count;
    int               error_count;
    int               base_seen;
    bit               aborted;

    tage_predictor uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .query_pc_i   (query_pc_i),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_taken_i  (upd_taken_i),
        .pred_taken_o (pred_taken_o),
        .provider_o   (provider_o),
        .ghr_o        (ghr_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Three-bit direction counter, clamped at both ends
    function automatic logic [CTR_W-1:0] step_counter(input logic [CTR_W-1:0] c, input logic t);
        if (t) begin
            return (c == 3'b111) ? c : c + 3'd1;
        end
        return (c == 3'b000) ? c : c - 3'd1;
    endfunction

    function automatic logic model_taken(input logic [PC_W-1:0] pc);
        return base_model[pc[BASE_IDX_W+1:2]][CTR_W-1];
    endfunction

    task automatic record_update(input logic v, input logic [PC_W-1:0] pc, input logic t);
        if (v) begin
            base_model[pc[BASE_IDX_W+1:2]] = step_counter(base_model[pc[BASE_IDX_W+1:2]], t);
            exp_ghr = {exp_ghr[GHR_W-2:0], t};
        end
    endtask

    task automatic check_taken(input logic got, input logic exp, input string where);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %0d ns: pred_taken_o = %0b, expected %0b (%s)",
                     $time, got, exp, where);
        end
    endtask

    task automatic check_provider(input provider_t got, input provider_t exp, input string where);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %0d ns: provider_o = %s, expected %s (%s)",
                     $time, got.name(), exp.name(), where);
        end
    endtask

    task automatic check_ghr(input logic [GHR_W-1:0] got, input logic [GHR_W-1:0] exp,
                             input string where);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %0d ns: ghr_o = %b, expected %b (%s)", $time, got, exp, where);
        end
    endtask

    // Inputs change just after the edge, outputs are read mid-cycle
    task automatic drive_and_settle(input logic [PC_W-1:0] q_pc, input logic u_valid,
                                    input logic [PC_W-1:0] u_pc, input logic u_taken);
        @(posedge clk);
        #2;
        query_pc_i  = q_pc;
        upd_valid_i = u_valid;
        upd_pc_i    = u_pc;
        upd_taken_i = u_taken;
        @(negedge clk);
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (!(rst_n === 1'b1 && ghr_o === '0) && n < RESET_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(rst_n === 1'b1 && ghr_o === '0)) begin
            $display("predictor did not come out of reset within %0d cycles", RESET_LIMIT);
            aborted = 1'b1;
        end
    endtask

    task automatic wait_ghr_settled();
        int n;
        n = 0;
        while (ghr_o !== exp_ghr && n < SETTLE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ghr_o !== exp_ghr) begin
            $display("history register never reached the expected value after the last update");
            aborted = 1'b1;
        end
    endtask

    task automatic run_case_file();
        int              fd;
        int              n_fields;
        int              lines_read;
        int              cases;
        int              errs_before;
        string           line;
        string           where;
        logic [PC_W-1:0] q_pc;
        logic [PC_W-1:0] u_pc;
        logic            u_valid;
        logic            u_taken;
        logic            e_taken;
        logic [7:0]      prov_ch;
        errs_before = error_count;
        lines_read = 0;
        cases = 0;
        fd = $fopen("tb/tage_cases.txt", "r");
        if (fd == 0) begin
            $display("case file tb/tage_cases.txt could not be opened");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd) && lines_read < MAX_LINES && !aborted) begin
            lines_read++;
            line = "";
            n_fields = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%h %h %h %h %h %c",
                               q_pc, u_valid, u_pc, u_taken, e_taken, prov_ch);
            if (n_fields != 6) begin
                $display("case file line %0d could not be parsed", lines_read);
                aborted = 1'b1;
            end else begin
                cases++;
                where = $sformatf("case line %0d", lines_read);
                drive_and_settle(q_pc, u_valid, u_pc, u_taken);
                check_ghr(ghr_o, exp_ghr, where);
                check_taken(pred_taken_o, e_taken, where);
                // Tag hits after the history turns nonzero are not predicted by the file
                if (prov_ch != "x") begin
                    check_provider(provider_o, provider_t'(prov_ch[1:0]), where);
                end
                record_update(u_valid, u_pc, u_taken);
            end
        end
        if (!$feof(fd) && !aborted) begin
            $display("case file has more than %0d lines", MAX_LINES);
            aborted = 1'b1;
        end
        $fclose(fd);
        if (cases == 0) begin
            $display("case file held no usable lines");
            aborted = 1'b1;
        end
        $display("test case_file: %0d cases, %0d errors", cases, error_count - errs_before);
    endtask

    // History always checked, direction only when the base table provides
    task automatic check_against_model(input logic [PC_W-1:0] pc, input string where);
        check_ghr(ghr_o, exp_ghr, where);
        if (provider_o == PROV_BASE) begin
            base_seen++;
            check_taken(pred_taken_o, model_taken(pc), where);
        end
    endtask

    task automatic run_random_updates();
        logic [PC_W-1:0] pc;
        logic            taken;
        int              r;
        int              errs_before;
        errs_before = error_count;
        base_seen = 0;
        for (r = 0; r < RANDOM_ROUNDS; r++) begin
            rand_state = lcg_step(rand_state);
            pc = {rand_state[31:2], 2'b00};
            rand_state = lcg_step(rand_state);
            taken = rand_state[16];
            drive_and_settle(pc, 1'b1, pc, taken);
            check_against_model(pc, $sformatf("random round %0d, update cycle", r));
            record_update(1'b1, pc, taken);
            drive_and_settle(pc, 1'b0, '0, 1'b0);
            check_against_model(pc, $sformatf("random round %0d, after update", r));
        end
        // Untrained tagged tables should leave most reads to the base table
        if (base_seen == 0) begin
            error_count++;
            $display("random updates never read a base table prediction");
        end
        $display("test random_updates: %0d rounds, %0d base reads, %0d errors",
                 RANDOM_ROUNDS, base_seen, error_count - errs_before);
    endtask

    initial begin
        int i;
        rst_n       = 1'b0;
        query_pc_i  = '0;
        upd_valid_i = 1'b0;
        upd_pc_i    = '0;
        upd_taken_i = 1'b0;
        for (i = 0; i < 2**BASE_IDX_W; i++) begin
            base_model[i] = CTR_RESET;
        end
        exp_ghr     = '0;
        rand_state  = 32'd36;
        check_count = 0;
        error_count = 0;
        base_seen   = 0;
        aborted     = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait_reset_done();
        if (!aborted) begin
            run_case_file();
        end
        if (!aborted) begin
            run_random_updates();
        end
        if (!aborted) begin
            wait_ghr_settled();
        end
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && !aborted) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
hdl/bp_geom_pkg.sv
hdl/bp_ctr_pkg.sv
hdl/bp_comp_if.sv
hdl/first_set_encoder.sv
hdl/history_reg.sv
hdl/bimodal_table.sv
hdl/tagged_predictor.sv
hdl/tage_predictor.sv
tb/tage_predictor_checker.sv
tb/tage_predictor_tb.sv
